//--- Bender.yml
package:
  name: load_store_unit

sources:
  - include_dirs:
      - .
    files:
      - lsu_pkg.sv
      - lsu_address_gen.sv
      - lsu_request_stage.sv
      - lsu_load_return.sv
      - load_store_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - tb_load_store_unit.sv

//--- load_store_unit.f
+incdir+.
lsu_pkg.sv
lsu_address_gen.sv
lsu_request_stage.sv
lsu_load_return.sv
load_store_unit.sv
tb_clock_gen.sv
tb_load_store_unit.sv

//--- load_store_unit.sv
// top level of the load/store pipe, connects address stage, request stage and load return
`default_nettype none

module load_store_unit (
    input  logic                clk,
    input  logic                rst,
    input  lsu_pkg::lsu_issue_t issue,
    input  logic                flush,
    output logic                busy,
    output lsu_pkg::mem_req_t   req,
    input  lsu_pkg::word_t      data_rdata,
    input  logic                data_resp,
    output lsu_pkg::wb_t        wb
);

    lsu_pkg::agu_out_t agu;
    lsu_pkg::mem_op_t  held_op;
    lsu_pkg::word_t    held_addr;

    // busy doubles as the stall of the address stage
    lsu_address_gen u_address_gen (
        .clk   (clk),
        .rst   (rst),
        .flush (flush),
        .stall (busy),
        .issue (issue),
        .agu   (agu)
    );

    lsu_request_stage u_request_stage (
        .clk       (clk),
        .rst       (rst),
        .agu       (agu),
        .data_resp (data_resp),
        .req       (req),
        .busy      (busy),
        .held_op   (held_op),
        .held_addr (held_addr)
    );

    lsu_load_return u_load_return (
        .clk        (clk),
        .rst        (rst),
        .held_op    (held_op),
        .held_addr  (held_addr),
        .data_rdata (data_rdata),
        .data_resp  (data_resp),
        .wb         (wb)
    );

endmodule : load_store_unit

`default_nettype wire

//--- lsu_address_gen.sv
// address stage of the load/store pipe: issue register, byte address, byte enables, store lanes
`default_nettype none

`include "lsu_consts.svh"

module lsu_address_gen (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              stall,
    input  lsu_pkg::lsu_issue_t issue,
    output lsu_pkg::agu_out_t   agu
);

    // control part of the issue register
    lsu_pkg::mem_op_t op_q;

    // operands travel with the op
    lsu_pkg::word_t base_q;
    lsu_pkg::word_t offset_q;
    lsu_pkg::word_t value_q;

    lsu_pkg::word_t        addr;
    lsu_pkg::word_t        wdata;
    logic [`LSU_MBE_W-1:0] mbe;

    // op is held while the request stage waits on memory
    always_ff @(posedge clk) begin
        if (rst) begin
            op_q <= '0;
        end else if (!stall) begin
            if (flush) begin
                // empty op, fn reads as none
                op_q <= '0;
            end else begin
                op_q <= issue.op;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            base_q   <= issue.base;
            offset_q <= issue.offset;
            value_q  <= issue.value;
        end
    end

    assign addr = base_q + offset_q;

    // enables follow the access size and the low address bits
    always_comb begin
        case (op_q.size)
            lsu_pkg::size_byte: begin
                mbe = `LSU_MBE_W'(1) << addr[1:0];
            end
            lsu_pkg::size_half: begin
                mbe = `LSU_MBE_W'(2'b11) << {addr[1], 1'b0};
            end
            default: begin
                mbe = '1;
            end
        endcase
    end

    // move the store value up to its byte lane
    assign wdata = value_q << {addr[1:0], 3'b000};

    always_comb begin
        agu = '{
            op:    op_q,
            addr:  addr,
            wdata: wdata,
            mbe:   mbe
        };
    end

endmodule : lsu_address_gen

`default_nettype wire

//--- lsu_consts.svh
// width constants for the load/store pipe, included by the package and the RTL that needs them
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// data word width, one RV32I register
`define LSU_XLEN 32

// destination register index width
`define LSU_REG_W 5

// one byte enable per byte lane of the data word
`define LSU_MBE_W 4

`endif

//--- lsu_load_return.sv
// load return of the load/store pipe: lane select, sign or zero extension, writeback register
`default_nettype none

`include "lsu_consts.svh"

module lsu_load_return (
    input  logic             clk,
    input  logic             rst,
    input  lsu_pkg::mem_op_t held_op,
    input  lsu_pkg::word_t   held_addr,
    input  lsu_pkg::word_t   data_rdata,
    input  logic             data_resp,
    output lsu_pkg::wb_t     wb
);

    logic [7:0]     lane_b;
    logic [15:0]    lane_h;
    lsu_pkg::word_t load_val;

    logic              valid_q;
    lsu_pkg::reg_idx_t rd_q;
    lsu_pkg::word_t    value_q;

    assign lane_b = data_rdata[{held_addr[1:0], 3'b000} +: 8];
    assign lane_h = data_rdata[{held_addr[1], 4'b0000} +: 16];

    always_comb begin
        case (held_op.size)
            lsu_pkg::size_byte: begin
                if (held_op.ext == lsu_pkg::ext_signed) begin
                    load_val = {{(`LSU_XLEN-8){lane_b[7]}}, lane_b};
                end else begin
                    load_val = {{(`LSU_XLEN-8){1'b0}}, lane_b};
                end
            end
            lsu_pkg::size_half: begin
                if (held_op.ext == lsu_pkg::ext_signed) begin
                    load_val = {{(`LSU_XLEN-16){lane_h[15]}}, lane_h};
                end else begin
                    load_val = {{(`LSU_XLEN-16){1'b0}}, lane_h};
                end
            end
            default: begin
                load_val = data_rdata;
            end
        endcase
    end

    // stores carry has_rd low, so only loads write back
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= held_op.has_rd && data_resp;
        end
    end

    always_ff @(posedge clk) begin
        rd_q    <= held_op.rd;
        value_q <= load_val;
    end

    always_comb begin
        wb = '{
            valid: valid_q,
            rd:    rd_q,
            value: value_q
        };
    end

endmodule : lsu_load_return

`default_nettype wire

//--- lsu_pkg.sv
// shared enums and packed structs of the load/store pipe, used by the RTL and the testbench
`default_nettype none

`include "lsu_consts.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0] word_t;
    typedef logic [`LSU_REG_W-1:0] reg_idx_t;

    // read on bit 1, write on bit 0
    typedef enum logic [1:0] {
        mem_none  = 2'b00,
        mem_write = 2'b01,
        mem_read  = 2'b10
    } mem_fn_t;

    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } mem_size_t;

    typedef enum logic {
        ext_signed = 1'b0,
        ext_zero   = 1'b1
    } load_ext_t;

    // all zero is an empty op
    typedef struct packed {
        mem_fn_t   fn;
        mem_size_t size;
        load_ext_t ext;
        logic      has_rd;
        reg_idx_t  rd;
    } mem_op_t;

    typedef struct packed {
        mem_op_t op;
        word_t   base;
        word_t   offset;
        word_t   value;
    } lsu_issue_t;

    // addr is the full byte address, wdata already shifted to its lanes
    typedef struct packed {
        mem_op_t                op;
        word_t                  addr;
        word_t                  wdata;
        logic [`LSU_MBE_W-1:0]  mbe;
    } agu_out_t;

    typedef struct packed {
        word_t                  addr;
        word_t                  wdata;
        logic                   read;
        logic                   write;
        logic [`LSU_MBE_W-1:0]  mbe;
    } mem_req_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    value;
    } wb_t;

endpackage

`default_nettype wire

//--- lsu_request_stage.sv
// request stage of the load/store pipe: holds the request in flight, drives the bus, makes busy
`default_nettype none

`include "lsu_consts.svh"

module lsu_request_stage (
    input  logic              clk,
    input  logic              rst,
    input  lsu_pkg::agu_out_t agu,
    input  logic              data_resp,
    output lsu_pkg::mem_req_t req,
    output logic              busy,
    output lsu_pkg::mem_op_t  held_op,
    output lsu_pkg::word_t    held_addr
);

    lsu_pkg::mem_op_t      op_q;
    lsu_pkg::word_t        addr_q;
    lsu_pkg::word_t        wdata_q;
    logic [`LSU_MBE_W-1:0] mbe_q;

    lsu_pkg::agu_out_t held;
    lsu_pkg::agu_out_t bus_src;

    // waiting on memory as long as a real op has no response yet
    assign busy = (op_q.fn != lsu_pkg::mem_none) && !data_resp;

    always_ff @(posedge clk) begin
        if (rst) begin
            op_q <= '0;
        end else if (!busy) begin
            op_q <= agu.op;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy) begin
            addr_q  <= agu.addr;
            wdata_q <= agu.wdata;
            mbe_q   <= agu.mbe;
        end
    end

    always_comb begin
        held = '{
            op:    op_q,
            addr:  addr_q,
            wdata: wdata_q,
            mbe:   mbe_q
        };
    end

    // a stalled request keeps the bus, otherwise the next op goes out at once
    assign bus_src = busy ? held : agu;

    always_comb begin
        req = '{
            addr:  {bus_src.addr[`LSU_XLEN-1:2], 2'b00},
            wdata: bus_src.wdata,
            read:  bus_src.op.fn == lsu_pkg::mem_read,
            write: bus_src.op.fn == lsu_pkg::mem_write,
            mbe:   bus_src.mbe
        };
    end

    // load return needs the op and the low address bits of the held request
    assign held_op   = op_q;
    assign held_addr = addr_q;

endmodule : lsu_request_stage

`default_nettype wire

//--- tb_clock_gen.sv
// testbench clock and reset source, period 8 with reset high for the first 5 cycles
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    end

endmodule : tb_clock_gen

`default_nettype wire

//--- tb_load_store_unit.sv
// testbench of the load/store pipe: random ops, bus memory model, reference model, in-order checks
`default_nettype none

`include "lsu_consts.svh"

module tb_load_store_unit;

    localparam int NUM_OPS     = 2000;
    localparam int RUN_LIMIT   = 40000;
    localparam int DRAIN_LIMIT = 200;

    logic                clk;
    logic                rst;
    lsu_pkg::lsu_issue_t issue;
    logic                flush;
    logic                busy;
    lsu_pkg::mem_req_t   req;
    lsu_pkg::word_t      data_rdata;
    logic                data_resp;
    lsu_pkg::wb_t        wb;

    logic [31:0] lfsr_state;

    // bus side memory is word wide, the reference copy is byte wide
    lsu_pkg::word_t mem [0:255];
    logic [7:0]     ref_mem [0:1023];

    lsu_pkg::mem_req_t exp_req_q [$];
    lsu_pkg::wb_t      exp_wb_q [$];
    // one flag per expected request, set for a load that writes back
    logic              wb_due_q [$];

    // request held by the memory model until it answers
    logic              pend_valid;
    lsu_pkg::mem_req_t pend_req;
    logic              pend_rd;
    int                wait_cnt;
    logic              resp_next;
    lsu_pkg::word_t    rdata_next;
    logic              wb_due;

    lsu_pkg::lsu_issue_t offer;
    logic                offer_taken;
    int                  accepted;
    int                  cov [0:2][0:1];

    tb_clock_gen u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    load_store_unit DUT (
        .clk        (clk),
        .rst        (rst),
        .issue      (issue),
        .flush      (flush),
        .busy       (busy),
        .req        (req),
        .data_rdata (data_rdata),
        .data_resp  (data_resp),
        .wb         (wb)
    );

    // Galois step, feedback taps applied when a one drops out
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // every byte lane depends on the whole word index
    function automatic lsu_pkg::word_t fill_word(input int w);
        return (32'(w) * 32'h01010101) ^ 32'hc36a95f0;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_req(input string name, input lsu_pkg::mem_req_t got,
                             input lsu_pkg::mem_req_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_wb(input string name, input lsu_pkg::wb_t got, input lsu_pkg::wb_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_idle();
        check_bit("busy", busy, 1'b0);
        check_bit("req.read", req.read, 1'b0);
        check_bit("req.write", req.write, 1'b0);
        check_bit("wb.valid", wb.valid, 1'b0);
    endtask

    function automatic lsu_pkg::lsu_issue_t make_op();
        lsu_pkg::lsu_issue_t t;
        logic [31:0]         r;
        logic [9:0]          ea;
        logic [11:0]         off12;
        t = '0;
        // one none op in eight, the rest split between stores and loads
        r = rand_bits(3);
        if (r[2:0] == 3'd0) begin
            t.op.fn = lsu_pkg::mem_none;
        end else if (r[2:0] < 3'd4) begin
            t.op.fn = lsu_pkg::mem_write;
        end else begin
            t.op.fn = lsu_pkg::mem_read;
        end
        r = rand_bits(2);
        if (r[1:0] == 2'd0) begin
            t.op.size = lsu_pkg::size_byte;
        end else if (r[1:0] == 2'd1) begin
            t.op.size = lsu_pkg::size_half;
        end else begin
            t.op.size = lsu_pkg::size_word;
        end
        r = rand_bits(1);
        t.op.ext = r[0] ? lsu_pkg::ext_zero : lsu_pkg::ext_signed;
        r = rand_bits(2);
        // stores never carry a destination register
        t.op.has_rd = (t.op.fn != lsu_pkg::mem_write) && (r[1:0] != 2'd0);
        r = rand_bits(5);
        t.op.rd = r[4:0];
        // effective address inside the model memory, aligned to the size
        r = rand_bits(10);
        ea = r[9:0];
        if (t.op.size == lsu_pkg::size_half) begin
            ea[0] = 1'b0;
        end else if (t.op.size == lsu_pkg::size_word) begin
            ea[1:0] = 2'b00;
        end
        r = rand_bits(12);
        off12 = r[11:0];
        t.offset = {{20{off12[11]}}, off12};
        t.base = {22'd0, ea} - t.offset;
        t.value = rand_bits(32);
        return t;
    endfunction

    // reference model of one accepted op
    task automatic accept_op(input lsu_pkg::lsu_issue_t op);
        lsu_pkg::word_t    ea;
        lsu_pkg::word_t    raw;
        lsu_pkg::mem_req_t r;
        lsu_pkg::wb_t      w;
        int                nbytes;
        int                off;
        int                i;
        ea = op.base + op.offset;
        off = int'(ea[1:0]);
        nbytes = (op.op.size == lsu_pkg::size_byte) ? 1 :
                 (op.op.size == lsu_pkg::size_half) ? 2 : 4;
        r = '0;
        r.addr = {ea[31:2], 2'b00};
        r.wdata = op.value << (8 * off);
        r.read = (op.op.fn == lsu_pkg::mem_read);
        r.write = (op.op.fn == lsu_pkg::mem_write);
        for (i = 0; i < `LSU_MBE_W; i++) begin
            r.mbe[i] = (i >= off) && (i < off + nbytes);
        end
        exp_req_q.push_back(r);
        wb_due_q.push_back(r.read && op.op.has_rd);
        if (r.write) begin
            for (i = 0; i < nbytes; i++) begin
                ref_mem[int'(ea[9:0]) + i] = op.value[8*i +: 8];
            end
        end else begin
            raw = '0;
            for (i = 0; i < nbytes; i++) begin
                raw[8*i +: 8] = ref_mem[int'(ea[9:0]) + i];
            end
            if (nbytes < 4 && op.op.ext == lsu_pkg::ext_signed && raw[8*nbytes-1]) begin
                for (i = 8 * nbytes; i < 32; i++) begin
                    raw[i] = 1'b1;
                end
            end
            if (op.op.has_rd) begin
                w = '{valid: 1'b1, rd: op.op.rd, value: raw};
                exp_wb_q.push_back(w);
                // only a load that writes back shows its extension
                cov[int'(op.op.size)][int'(op.op.ext)]++;
            end
        end
        accepted++;
    endtask

    // sampled at the falling edge, decides what happens at the next rising edge
    task automatic model_cycle();
        logic [31:0] r;
        int          i;
        // a writeback follows a load response by exactly one cycle
        check_bit("wb.valid", wb.valid, wb_due);
        if (wb.valid) begin
            check_wb("wb", wb, exp_wb_q.pop_front());
        end
        // a response in this cycle retires the held request
        if (data_resp) begin
            pend_valid = 1'b0;
            wb_due = pend_rd;
        end else begin
            wb_due = 1'b0;
        end
        check_bit("busy", busy, pend_valid);
        if (pend_valid) begin
            check_req("req", req, pend_req);
        end else if (req.read || req.write) begin
            if (exp_req_q.size() == 0) begin
                stop_with_failure("request on the bus that no accepted op explains");
            end
            check_req("req", req, exp_req_q.pop_front());
            pend_req = req;
            pend_rd = wb_due_q.pop_front();
            pend_valid = 1'b1;
            r = rand_bits(2);
            wait_cnt = int'(r[1:0]);
        end
        if (!busy && !flush && issue.op.fn != lsu_pkg::mem_none) begin
            accept_op(issue);
        end
        offer_taken = !busy;
        resp_next = 1'b0;
        if (pend_valid) begin
            if (wait_cnt == 0) begin
                resp_next = 1'b1;
                if (pend_req.write) begin
                    for (i = 0; i < `LSU_MBE_W; i++) begin
                        if (pend_req.mbe[i]) begin
                            mem[pend_req.addr[9:2]][8*i +: 8] = pend_req.wdata[8*i +: 8];
                        end
                    end
                end
                rdata_next = mem[pend_req.addr[9:2]];
            end else begin
                wait_cnt--;
            end
        end
    endtask

    task automatic drive_inputs(input logic issuing);
        logic [31:0] r;
        data_resp <= resp_next;
        data_rdata <= resp_next ? rdata_next : '0;
        if (issuing) begin
            // a new op only once the one on offer has left the issuer
            if (offer_taken) begin
                offer = make_op();
            end
            r = rand_bits(3);
            flush <= (r[2:0] == 3'd0);
        end else begin
            offer = '0;
            flush <= 1'b0;
        end
        issue <= offer;
    endtask

    initial begin
        int   n;
        int   s;
        int   e;
        logic hole;
        lsu_pkg::word_t fw;
        lfsr_state = 32'h35e7ceb2;
        issue = '0;
        flush = 1'b0;
        data_rdata = '0;
        data_resp = 1'b0;
        offer = '0;
        offer_taken = 1'b1;
        pend_valid = 1'b0;
        pend_req = '0;
        pend_rd = 1'b0;
        wait_cnt = 0;
        resp_next = 1'b0;
        rdata_next = '0;
        wb_due = 1'b0;
        accepted = 0;
        for (s = 0; s < 3; s++) begin
            cov[s][0] = 0;
            cov[s][1] = 0;
        end
        for (s = 0; s < 256; s++) begin
            fw = fill_word(s);
            mem[s] = fw;
            for (e = 0; e < 4; e++) begin
                ref_mem[4*s + e] = fw[8*e +: 8];
            end
        end

        // registers are clear once the first edge has passed
        @(posedge clk);
        n = 0;
        while (rst) begin
            @(negedge clk);
            check_idle();
            n++;
            if (n > 20) begin
                stop_with_failure("reset was not released within 20 cycles");
            end
        end

        n = 0;
        while (accepted < NUM_OPS) begin
            @(posedge clk);
            drive_inputs(1'b1);
            @(negedge clk);
            model_cycle();
            n++;
            if (n > RUN_LIMIT) begin
                stop_with_failure("timed out before all ops were accepted");
            end
        end

        n = 0;
        while (exp_req_q.size() != 0 || exp_wb_q.size() != 0 || pend_valid) begin
            @(posedge clk);
            drive_inputs(1'b0);
            @(negedge clk);
            model_cycle();
            n++;
            if (n > DRAIN_LIMIT) begin
                stop_with_failure("timed out waiting for the pipe to drain");
            end
        end

        // quiet cycles catch a stray request or writeback
        repeat (4) begin
            @(posedge clk);
            drive_inputs(1'b0);
            @(negedge clk);
            model_cycle();
        end

        hole = 1'b0;
        for (s = 0; s < 3; s++) begin
            for (e = 0; e < 2; e++) begin
                if (cov[s][e] == 0) begin
                    $display("no accepted op with size %0d and extension %0d", s, e);
                    hole = 1'b1;
                end
            end
        end
        if (hole) begin
            stop_with_failure("not every size and extension was exercised");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule : tb_load_store_unit

`default_nettype wire
